/* src/sys_pkg.sv */
`default_nettype none

package sys_pkg;

   typedef logic [15:0] bus_addr_t;     // cpu address
   typedef logic [7:0]  bus_data_t;     // bus data byte
   typedef logic [19:0] timer_ticks_t;  // timer period / count

   localparam int NUM_TIMERS = 8;

   // system-control page, low address byte
   localparam logic [7:0] SYS_REG_SPEED      = 8'h00;
   localparam logic [7:0] SYS_REG_TIMER_SEL  = 8'h01;
   localparam logic [7:0] SYS_REG_TICKS_L    = 8'h02;
   localparam logic [7:0] SYS_REG_TICKS_M    = 8'h03;
   localparam logic [7:0] SYS_REG_TICKS_H    = 8'h04;
   localparam logic [7:0] SYS_REG_TIMER_LOAD = 8'h05;
   localparam logic [7:0] SYS_REG_TIMER_EN   = 8'h06;
   localparam logic [7:0] SYS_REG_IRQ        = 8'h07;
   localparam logic [7:0] SYS_REG_UART_STAT  = 8'h08;
   localparam logic [7:0] SYS_REG_UART_DATA  = 8'h09;

   typedef enum logic {
      BUS_IDLE,
      BUS_READ   // waiting for slow targets
   } bus_state_e;

endpackage

`default_nettype wire

/* src/edge_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_detector (
   input  wire  sys_clk,
   input  wire  reset_n,
   input  wire  level,
   output logic rising
);

   logic level_q;  // previous sample

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         level_q <= 1'b0;
         rising  <= 1'b0;
      end else begin
         level_q <= level;
         rising  <= level & ~level_q;  // one cycle pulse
      end
   end

endmodule

`default_nettype wire

/* src/interval_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module interval_timer (
   input  wire                   sys_clk,
   input  wire                   reset_n,
   input  wire                   enable,
   input  wire                   load,
   input  wire                   irq_ack,
   input  wire sys_pkg::timer_ticks_t max_ticks,
   output sys_pkg::timer_ticks_t value,
   output logic                  irq
);

   sys_pkg::timer_ticks_t max_q;  // period taken on load
   logic                  terminal;

   assign terminal = enable && !load && (value == max_q);

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         value <= '0;
         max_q <= '0;
         irq   <= 1'b0;
      end else begin
         if (load) begin
            value <= '0;
            max_q <= max_ticks;
         end else if (enable) begin
            if (terminal) begin
               value <= '0;  // reload
            end else begin
               value <= value + 20'd1;
            end
         end

         // a new terminal count wins over ack
         if (terminal) begin
            irq <= 1'b1;
         end else if (irq_ack) begin
            irq <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* src/uart_link.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_link #(
   parameter int CLKS_PER_BIT = 868
) (
   input  wire                  sys_clk,
   input  wire                  reset_n,
   input  wire                  uart_rx,
   output logic                 uart_tx,
   input  wire sys_pkg::bus_data_t wr_data,
   input  wire                  wr_en,
   output logic                 wr_busy,
   input  wire                  rd_req,
   output logic                 rd_wait,
   output logic                 rd_avail,
   output sys_pkg::bus_data_t   rd_data
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   logic [9:0]       tx_shift;  // stop, data, start
   logic [3:0]       tx_bits;
   logic [CNT_W-1:0] tx_cnt;

   logic             rx_meta;
   logic             rx_sync;
   rx_state_e        rx_state;
   logic [CNT_W-1:0] rx_cnt;
   logic [2:0]       rx_idx;
   logic [7:0]       rx_shift;
   logic             rx_sample;
   logic             rx_done;

   assign uart_tx = tx_shift[0];

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         tx_shift <= '1;  // line idles high
         tx_bits  <= '0;
         tx_cnt   <= '0;
         wr_busy  <= 1'b0;
      end else if (!wr_busy) begin
         if (wr_en) begin
            tx_shift <= {1'b1, wr_data, 1'b0};
            tx_bits  <= 4'd10;
            tx_cnt   <= '0;
            wr_busy  <= 1'b1;
         end
      end else if (tx_cnt == BIT_LAST) begin
         tx_cnt   <= '0;
         tx_shift <= {1'b1, tx_shift[9:1]};
         tx_bits  <= tx_bits - 4'd1;
         if (tx_bits == 4'd1) begin
            wr_busy <= 1'b0;  // end of stop bit
         end
      end else begin
         tx_cnt <= tx_cnt + 1'b1;
      end
   end

   assign rx_sample = (rx_state == RX_DATA) && (rx_cnt == BIT_LAST);
   assign rx_done   = (rx_state == RX_STOP) && (rx_cnt == BIT_LAST) && rx_sync;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         rx_meta  <= 1'b1;
         rx_sync  <= 1'b1;
         rx_state <= RX_IDLE;
         rx_cnt   <= '0;
         rx_idx   <= '0;
      end else begin
         rx_meta <= uart_rx;
         rx_sync <= rx_meta;
         case (rx_state)
            RX_IDLE: begin
               rx_cnt <= '0;
               if (!rx_sync) begin
                  rx_state <= RX_START;
               end
            end
            RX_START: begin
               if (rx_cnt == HALF_LAST) begin
                  rx_cnt   <= '0;
                  rx_idx   <= '0;
                  rx_state <= rx_sync ? RX_IDLE : RX_DATA;  // glitch check
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (rx_cnt == BIT_LAST) begin
                  rx_cnt <= '0;
                  rx_idx <= rx_idx + 3'd1;
                  if (rx_idx == 3'd7) begin
                     rx_state <= RX_STOP;
                  end
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            default: begin
               if (rx_cnt == BIT_LAST) begin
                  rx_state <= RX_IDLE;  // mid stop bit
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (rx_sample) begin
         rx_shift <= {rx_sync, rx_shift[7:1]};  // lsb first
      end
      if (rx_done) begin
         rd_data <= rx_shift;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         rd_wait  <= 1'b0;
         rd_avail <= 1'b0;
      end else begin
         rd_wait <= rd_req;
         if (rx_done) begin
            rd_avail <= 1'b1;  // newer frame overwrites
         end else if (rd_wait) begin
            rd_avail <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* src/sys_ctl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_ctl_regs #(
   parameter int CLKS_PER_BIT = 868
) (
   input  wire                  sys_clk,
   input  wire                  reset_n,
   input  wire                  sel,
   input  wire [7:0]            reg_addr,
   input  wire                  wr_en,
   input  wire sys_pkg::bus_data_t wr_data,
   input  wire                  rd_start,
   output sys_pkg::bus_data_t   rd_data,
   output logic                 rd_pending,
   output logic                 irq_n,
   output logic                 cpu_clk_en,
   input  wire                  uart_rx,
   output logic                 uart_tx
);

   localparam int NT    = sys_pkg::NUM_TIMERS;
   localparam int SEL_W = $clog2(NT);

   logic                  wr_hit;
   logic                  rd_hit;
   logic [2:0]            speed;
   logic [SEL_W-1:0]      timer_sel;
   logic [NT-1:0]         timer_en;
   logic [NT-1:0]         timer_load;
   logic [NT-1:0]         timer_ack;
   logic [NT-1:0]         timer_irq;
   logic [NT-1:0]         irq_bits;
   sys_pkg::timer_ticks_t timer_ticks [NT];
   sys_pkg::timer_ticks_t timer_value [NT];
   sys_pkg::timer_ticks_t tick_view;

   logic                  uart_wr_en;
   logic                  uart_wr_busy;
   logic                  uart_rd_req;
   logic                  uart_rd_wait;
   logic                  uart_rd_avail;
   sys_pkg::bus_data_t    uart_rd_data;

   logic [4:0]            div_cnt;
   logic                  div_tap;
   logic                  tap_rise;

   assign wr_hit     = sel & wr_en;
   assign rd_hit     = sel & rd_start;
   assign uart_wr_en = wr_hit && (reg_addr == sys_pkg::SYS_REG_UART_DATA);
   assign rd_pending = uart_rd_req | uart_rd_wait;
   assign irq_n      = ~|timer_irq;
   assign tick_view  = timer_en[timer_sel] ? timer_value[timer_sel] : timer_ticks[timer_sel];

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         speed     <= '0;
         timer_sel <= '0;
         timer_en  <= '0;
      end else if (wr_hit) begin
         case (reg_addr)
            sys_pkg::SYS_REG_SPEED:     speed <= wr_data[2:0];
            sys_pkg::SYS_REG_TIMER_SEL: timer_sel <= wr_data[SEL_W-1:0];
            sys_pkg::SYS_REG_TIMER_EN:  timer_en[timer_sel] <= wr_data[0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (wr_hit) begin
         case (reg_addr)
            sys_pkg::SYS_REG_TICKS_L: timer_ticks[timer_sel][7:0]   <= wr_data;
            sys_pkg::SYS_REG_TICKS_M: timer_ticks[timer_sel][15:8]  <= wr_data;
            sys_pkg::SYS_REG_TICKS_H: timer_ticks[timer_sel][19:16] <= wr_data[3:0];
            default: ;
         endcase
      end
   end

   genvar i;
   generate
      for (i = 0; i < NT; i++) begin : g_timer
         assign timer_load[i]      = wr_hit && (reg_addr == sys_pkg::SYS_REG_TIMER_LOAD) &&
                                     (timer_sel == SEL_W'(i));
         assign timer_ack[i]       = wr_hit && (reg_addr == sys_pkg::SYS_REG_IRQ) &&
                                     (timer_sel == SEL_W'(i));
         assign irq_bits[NT-1-i]   = timer_irq[i];  // timer 0 at msb

         interval_timer u_timer (
            .sys_clk   (sys_clk),
            .reset_n   (reset_n),
            .enable    (timer_en[i]),
            .load      (timer_load[i]),
            .irq_ack   (timer_ack[i]),
            .max_ticks (timer_ticks[i]),
            .value     (timer_value[i]),
            .irq       (timer_irq[i])
         );
      end
   endgenerate

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         uart_rd_req <= 1'b0;
      end else begin
         uart_rd_req <= rd_hit && (reg_addr == sys_pkg::SYS_REG_UART_DATA);  // pop
      end
   end

   always_ff @(posedge sys_clk) begin
      if (rd_hit) begin
         case (reg_addr)
            sys_pkg::SYS_REG_SPEED:     rd_data <= {5'b0, speed};
            sys_pkg::SYS_REG_TIMER_SEL: rd_data <= {{(8 - SEL_W){1'b0}}, timer_sel};
            sys_pkg::SYS_REG_TICKS_L:   rd_data <= tick_view[7:0];
            sys_pkg::SYS_REG_TICKS_M:   rd_data <= tick_view[15:8];
            sys_pkg::SYS_REG_TICKS_H:   rd_data <= {4'b0, tick_view[19:16]};
            sys_pkg::SYS_REG_TIMER_EN:  rd_data <= {7'b0, timer_en[timer_sel]};
            sys_pkg::SYS_REG_IRQ:       rd_data <= irq_bits;
            sys_pkg::SYS_REG_UART_STAT: rd_data <= {6'b0, uart_wr_busy, uart_rd_avail};
            sys_pkg::SYS_REG_UART_DATA: rd_data <= uart_rd_data;
            default:                    rd_data <= 8'h00;
         endcase
      end
   end

   uart_link #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_uart (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .uart_rx  (uart_rx),
      .uart_tx  (uart_tx),
      .wr_data  (wr_data),
      .wr_en    (uart_wr_en),
      .wr_busy  (uart_wr_busy),
      .rd_req   (uart_rd_req),
      .rd_wait  (uart_rd_wait),
      .rd_avail (uart_rd_avail),
      .rd_data  (uart_rd_data)
   );

   always_comb begin
      case (speed)
         3'd0:    div_tap = 1'b1;  // no edges, see cpu_clk_en
         3'd1:    div_tap = div_cnt[0];
         3'd2:    div_tap = div_cnt[1];
         3'd3:    div_tap = div_cnt[2];
         3'd4:    div_tap = div_cnt[3];
         default: div_tap = div_cnt[4];
      endcase
   end

   edge_detector u_tap_edge (
      .sys_clk (sys_clk),
      .reset_n (reset_n),
      .level   (div_tap),
      .rising  (tap_rise)
   );

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         div_cnt    <= '0;
         cpu_clk_en <= 1'b1;
      end else begin
         div_cnt    <= div_cnt + 5'd1;
         cpu_clk_en <= (speed == 3'd0) | tap_rise;
      end
   end

endmodule

`default_nettype wire

/* src/spram.sv */
`timescale 1ns/1ps
`default_nettype none

module spram #(
   parameter int ADDR_W = 15
) (
   input  wire                  sys_clk,
   input  wire [ADDR_W-1:0]     addr,
   input  wire                  wr_en,
   input  wire sys_pkg::bus_data_t wr_data,
   output sys_pkg::bus_data_t   rd_data
);

   sys_pkg::bus_data_t mem [2**ADDR_W];

   always_ff @(posedge sys_clk) begin
      if (wr_en) begin
         mem[addr] <= wr_data;
      end
      rd_data <= mem[addr];  // read before write
   end

endmodule

`default_nettype wire

/* src/bus_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_controller (
   input  wire                  sys_clk,
   input  wire                  reset_n,
   input  wire sys_pkg::bus_addr_t cpu_addr,
   input  wire                  cpu_wr_en,
   input  wire                  rd_start,
   input  wire sys_pkg::bus_data_t ram_rd_data,
   input  wire sys_pkg::bus_data_t sys_rd_data,
   input  wire                  rd_pending,
   output logic                 ram_wr_en,
   output logic                 sys_sel,
   output sys_pkg::bus_data_t   cpu_rd_data,
   output logic                 cpu_ready
);

   logic                ram_s;
   logic                ram_cs;
   logic                sys_cs;
   sys_pkg::bus_state_e bus_state;

   // 0x0000 - 0x8fff
   assign ram_s     = !cpu_addr[15] || (cpu_addr[15:12] == 4'h8);
   assign sys_sel   = (cpu_addr[15:8] == 8'h93);
   assign ram_wr_en = cpu_wr_en & ram_s;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         bus_state <= sys_pkg::BUS_IDLE;
         cpu_ready <= 1'b1;
         ram_cs    <= 1'b0;
         sys_cs    <= 1'b0;
      end else begin
         if (rd_start || cpu_wr_en) begin
            ram_cs <= ram_s;
            sys_cs <= sys_sel;
         end
         if (rd_start) begin
            bus_state <= sys_pkg::BUS_READ;
            cpu_ready <= 1'b0;
         end else if (bus_state == sys_pkg::BUS_READ && !rd_pending) begin
            bus_state <= sys_pkg::BUS_IDLE;  // read data settled
            cpu_ready <= 1'b1;
         end
      end
   end

   always_comb begin
      if (ram_cs) begin
         cpu_rd_data = ram_rd_data;
      end else if (sys_cs) begin
         cpu_rd_data = sys_rd_data;
      end else begin
         cpu_rd_data = 8'hFF;  // unmapped
      end
   end

endmodule

`default_nettype wire

/* src/sys_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_bus_top #(
   parameter int RAM_ADDR_W   = 15,
   parameter int CLKS_PER_BIT = 868
) (
   input  wire                  sys_clk,
   input  wire                  reset_n,
   input  wire sys_pkg::bus_addr_t cpu_addr,
   input  wire sys_pkg::bus_data_t cpu_wr_data,
   input  wire                  cpu_wr_en,
   input  wire                  cpu_rd_req,
   output sys_pkg::bus_data_t   cpu_rd_data,
   output logic                 cpu_ready,
   output logic                 cpu_clk_en,
   output logic                 irq_n,
   input  wire                  uart_rx,
   output logic                 uart_tx
);

   logic               rd_start;
   logic               ram_wr_en;
   logic               sys_sel;
   logic               rd_pending;
   sys_pkg::bus_data_t ram_rd_data;
   sys_pkg::bus_data_t sys_rd_data;

   edge_detector u_rd_edge (
      .sys_clk (sys_clk),
      .reset_n (reset_n),
      .level   (cpu_rd_req),
      .rising  (rd_start)
   );

   bus_controller u_bus (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .cpu_addr    (cpu_addr),
      .cpu_wr_en   (cpu_wr_en),
      .rd_start    (rd_start),
      .ram_rd_data (ram_rd_data),
      .sys_rd_data (sys_rd_data),
      .rd_pending  (rd_pending),
      .ram_wr_en   (ram_wr_en),
      .sys_sel     (sys_sel),
      .cpu_rd_data (cpu_rd_data),
      .cpu_ready   (cpu_ready)
   );

   spram #(
      .ADDR_W (RAM_ADDR_W)
   ) u_ram (
      .sys_clk (sys_clk),
      .addr    (cpu_addr[RAM_ADDR_W-1:0]),  // aliases above ram size
      .wr_en   (ram_wr_en),
      .wr_data (cpu_wr_data),
      .rd_data (ram_rd_data)
   );

   sys_ctl_regs #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_sys (
      .sys_clk    (sys_clk),
      .reset_n    (reset_n),
      .sel        (sys_sel),
      .reg_addr   (cpu_addr[7:0]),
      .wr_en      (cpu_wr_en),
      .wr_data    (cpu_wr_data),
      .rd_start   (rd_start),
      .rd_data    (sys_rd_data),
      .rd_pending (rd_pending),
      .irq_n      (irq_n),
      .cpu_clk_en (cpu_clk_en),
      .uart_rx    (uart_rx),
      .uart_tx    (uart_tx)
   );

endmodule

`default_nettype wire

/* tb/tb_sys_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sys_bus;

   localparam int RAM_ADDR_W   = 12;
   localparam int CLKS_PER_BIT = 8;
   localparam int RAM_SIZE     = 2 ** RAM_ADDR_W;
   localparam int CLK_NS       = 4;
   localparam int WAIT_LIMIT   = 2000;  // cycles
   localparam int POLL_LIMIT   = 200;   // status reads

   logic               sys_clk;
   logic               reset_n;
   sys_pkg::bus_addr_t cpu_addr;
   sys_pkg::bus_data_t cpu_wr_data;
   logic               cpu_wr_en;
   logic               cpu_rd_req;
   sys_pkg::bus_data_t cpu_rd_data;
   logic               cpu_ready;
   logic               cpu_clk_en;
   logic               irq_n;
   wire                uart_rx;
   logic               uart_tx;
   logic               loop_en;

   int errors;
   int checks;
   bit hung;

   sys_pkg::bus_data_t    ram_model [RAM_SIZE];
   bit                    ram_known [RAM_SIZE];
   sys_pkg::bus_addr_t    written_q [$];
   sys_pkg::timer_ticks_t period_model [sys_pkg::NUM_TIMERS];
   bit                    enable_model [sys_pkg::NUM_TIMERS];
   sys_pkg::bus_data_t    irq_model;

   assign uart_rx = loop_en ? uart_tx : 1'b1;  // loopback after reset

   sys_bus_top #(
      .RAM_ADDR_W   (RAM_ADDR_W),
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) uut (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .cpu_addr    (cpu_addr),
      .cpu_wr_data (cpu_wr_data),
      .cpu_wr_en   (cpu_wr_en),
      .cpu_rd_req  (cpu_rd_req),
      .cpu_rd_data (cpu_rd_data),
      .cpu_ready   (cpu_ready),
      .cpu_clk_en  (cpu_clk_en),
      .irq_n       (irq_n),
      .uart_rx     (uart_rx),
      .uart_tx     (uart_tx)
   );

   initial sys_clk = 1'b0;
   always #(CLK_NS / 2) sys_clk = ~sys_clk;

   task automatic check_value(input string sig, input string ctx,
                              input logic [31:0] got, input logic [31:0] exp);
      if (!hung) begin
         checks++;
         assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h (%s)",
                     $time, sig, got, exp, ctx);
         end
      end
   endtask

   task automatic check_near(input string sig, input int got, input int exp);
      if (!hung) begin
         checks++;
         assert (got >= exp - 1 && got <= exp + 1) else begin
            errors++;
            $display("mismatch at %0t ns: %s got %0d expected %0d +/- 1",
                     $time, sig, got, exp);
         end
      end
   endtask

   task automatic wait_ready(input logic level, input string what);
      int n;
      n = 0;
      while (!hung && cpu_ready !== level) begin
         @(negedge sys_clk);
         n++;
         if (n >= WAIT_LIMIT) begin
            hung = 1'b1;
            $display("timeout at %0t ns: cpu_ready never reached %b during %s",
                     $time, level, what);
         end
      end
   endtask

   task automatic wait_irq(input logic level);
      int n;
      n = 0;
      while (!hung && irq_n !== level) begin
         @(negedge sys_clk);
         n++;
         if (n >= WAIT_LIMIT) begin
            hung = 1'b1;
            $display("timeout at %0t ns: irq_n never went %b", $time, level);
         end
      end
   endtask

   task automatic bus_write(input sys_pkg::bus_addr_t addr, input sys_pkg::bus_data_t data);
      if (!hung) begin
         wait_ready(1'b1, "write");
         cpu_addr    = addr;
         cpu_wr_data = data;
         cpu_wr_en   = 1'b1;  // one cycle strobe
         @(negedge sys_clk);
         cpu_wr_en   = 1'b0;
      end
   endtask

   task automatic bus_read(input sys_pkg::bus_addr_t addr, output sys_pkg::bus_data_t data);
      data = 8'hxx;
      if (!hung) begin
         wait_ready(1'b1, "read setup");
         cpu_addr   = addr;
         cpu_rd_req = 1'b1;
         @(negedge sys_clk);
         wait_ready(1'b0, "read start");
         wait_ready(1'b1, "read data");
         data       = cpu_rd_data;
         cpu_rd_req = 1'b0;
         @(negedge sys_clk);  // gap so the next rise is seen
      end
   endtask

   task automatic write_reg(input logic [7:0] offset, input sys_pkg::bus_data_t data);
      bus_write({8'h93, offset}, data);
   endtask

   task automatic read_reg(input logic [7:0] offset, output sys_pkg::bus_data_t data);
      bus_read({8'h93, offset}, data);
   endtask

   task automatic poll_status(input int bit_idx, input logic level, input string what);
      sys_pkg::bus_data_t stat;
      int n;
      n = 0;
      read_reg(sys_pkg::SYS_REG_UART_STAT, stat);
      while (!hung && stat[bit_idx] !== level) begin
         n++;
         if (n >= POLL_LIMIT) begin
            hung = 1'b1;
            $display("timeout at %0t ns: UART status never showed %s", $time, what);
         end else begin
            read_reg(sys_pkg::SYS_REG_UART_STAT, stat);
         end
      end
   endtask

   initial begin : main_flow
      sys_pkg::bus_data_t    rd;
      sys_pkg::bus_data_t    tx;
      sys_pkg::bus_addr_t    addr;
      sys_pkg::timer_ticks_t ticks;
      int                    t;
      int                    pulses;
      time                   t_en;

      void'($urandom(32'h88cc_d4ac));
      errors      = 0;
      checks      = 0;
      hung        = 1'b0;
      irq_model   = 8'h00;
      reset_n     = 1'b0;
      cpu_addr    = '0;
      cpu_wr_data = '0;
      cpu_wr_en   = 1'b0;
      cpu_rd_req  = 1'b0;
      loop_en     = 1'b0;
      repeat (10) @(negedge sys_clk);
      reset_n = 1'b1;
      loop_en = 1'b1;
      @(negedge sys_clk);
      check_value("cpu_ready", "after reset", cpu_ready, 1'b1);
      check_value("irq_n", "after reset", irq_n, 1'b1);
      check_value("uart_tx", "after reset", uart_tx, 1'b1);

      // ram with 4 KB aliasing
      for (int i = 0; i < 200; i++) begin
         addr = 16'($urandom_range(16'h8FFF));
         tx   = 8'($urandom);
         bus_write(addr, tx);
         ram_model[addr[RAM_ADDR_W-1:0]] = tx;
         if (!ram_known[addr[RAM_ADDR_W-1:0]]) begin
            ram_known[addr[RAM_ADDR_W-1:0]] = 1'b1;
            written_q.push_back(addr);
         end
      end
      for (int i = 0; i < 200; i++) begin
         addr        = written_q[$urandom_range(written_q.size() - 1)];
         addr[15:12] = 4'($urandom_range(8));  // any alias up to 0x8fff
         bus_read(addr, rd);
         check_value("cpu_rd_data", $sformatf("ram read %h", addr), rd,
                     ram_model[addr[RAM_ADDR_W-1:0]]);
      end
      for (int i = 0; i < 40; i++) begin
         addr = 16'h9000 + 16'($urandom_range(16'h6FFF));
         if (addr[15:8] == 8'h93) begin
            addr[15:8] = 8'h94;
         end
         bus_read(addr, rd);
         check_value("cpu_rd_data", $sformatf("unmapped read %h", addr), rd, 8'hFF);
      end

      // timer periods, disabled readback
      for (int k = 0; k < sys_pkg::NUM_TIMERS; k++) begin
         ticks           = 20'($urandom);
         period_model[k] = ticks;
         enable_model[k] = 1'b0;
         write_reg(sys_pkg::SYS_REG_TIMER_SEL, 8'(k));
         write_reg(sys_pkg::SYS_REG_TICKS_L, ticks[7:0]);
         write_reg(sys_pkg::SYS_REG_TICKS_M, ticks[15:8]);
         write_reg(sys_pkg::SYS_REG_TICKS_H, {4'($urandom), ticks[19:16]});  // junk upper nibble
         write_reg(sys_pkg::SYS_REG_TIMER_LOAD, 8'h00);
         write_reg(sys_pkg::SYS_REG_TIMER_EN, 8'h00);
      end
      for (int k = 0; k < sys_pkg::NUM_TIMERS; k++) begin
         write_reg(sys_pkg::SYS_REG_TIMER_SEL, 8'(k));
         read_reg(sys_pkg::SYS_REG_TIMER_SEL, rd);
         check_value("timer_sel", $sformatf("timer %0d", k), rd, k);
         read_reg(sys_pkg::SYS_REG_TICKS_L, rd);
         check_value("ticks_l", $sformatf("timer %0d", k), rd, period_model[k][7:0]);
         read_reg(sys_pkg::SYS_REG_TICKS_M, rd);
         check_value("ticks_m", $sformatf("timer %0d", k), rd, period_model[k][15:8]);
         read_reg(sys_pkg::SYS_REG_TICKS_H, rd);
         check_value("ticks_h", $sformatf("timer %0d", k), rd, period_model[k][19:16]);
         read_reg(sys_pkg::SYS_REG_TIMER_EN, rd);
         check_value("timer_en", $sformatf("timer %0d", k), rd, enable_model[k]);
      end

      // timer interrupts
      repeat (3) begin
         t               = $urandom_range(sys_pkg::NUM_TIMERS - 1);
         ticks           = 20'($urandom_range(60, 4));
         period_model[t] = ticks;
         write_reg(sys_pkg::SYS_REG_TIMER_SEL, 8'(t));
         write_reg(sys_pkg::SYS_REG_TICKS_L, ticks[7:0]);
         write_reg(sys_pkg::SYS_REG_TICKS_M, ticks[15:8]);
         write_reg(sys_pkg::SYS_REG_TICKS_H, {4'h0, ticks[19:16]});
         write_reg(sys_pkg::SYS_REG_TIMER_LOAD, 8'h00);
         write_reg(sys_pkg::SYS_REG_TIMER_EN, 8'h01);
         t_en            = $time;
         enable_model[t] = 1'b1;
         read_reg(sys_pkg::SYS_REG_TIMER_EN, rd);
         check_value("timer_en", $sformatf("timer %0d on", t), rd, enable_model[t]);
         wait_irq(1'b0);
         irq_model[7 - t] = 1'b1;  // timer 0 at msb
         // counts 0 to period, flag lands one edge later
         check_value("irq_n", $sformatf("timer %0d cycles to fire", t),
                     ($time - t_en) / CLK_NS, ticks + 1);
         read_reg(sys_pkg::SYS_REG_IRQ, rd);
         check_value("irq_bits", $sformatf("timer %0d fired", t), rd, irq_model);
         write_reg(sys_pkg::SYS_REG_TIMER_EN, 8'h00);  // stop before ack
         enable_model[t] = 1'b0;
         write_reg(sys_pkg::SYS_REG_IRQ, 8'h00);
         irq_model[7 - t] = 1'b0;
         read_reg(sys_pkg::SYS_REG_IRQ, rd);
         check_value("irq_bits", $sformatf("timer %0d acked", t), rd, irq_model);
         check_value("irq_n", $sformatf("timer %0d acked", t), irq_n, irq_model == 8'h00);
      end

      // clock enable throttle
      for (int s = 0; s <= 5; s++) begin
         write_reg(sys_pkg::SYS_REG_SPEED, 8'(s));
         read_reg(sys_pkg::SYS_REG_SPEED, rd);
         check_value("speed", $sformatf("speed %0d", s), rd, s);
         repeat (40) @(negedge sys_clk);
         pulses = 0;
         repeat (320) begin
            @(negedge sys_clk);
            if (cpu_clk_en) begin
               pulses++;
            end
         end
         check_near($sformatf("cpu_clk_en pulses at speed %0d", s), pulses, 320 >> s);
      end
      write_reg(sys_pkg::SYS_REG_SPEED, 8'h00);

      // uart loopback
      repeat (6) begin
         tx = 8'($urandom);
         write_reg(sys_pkg::SYS_REG_UART_DATA, tx);
         read_reg(sys_pkg::SYS_REG_UART_STAT, rd);
         check_value("uart_stat busy", $sformatf("sent %h", tx), rd[1], 1'b1);
         poll_status(0, 1'b1, "receive avail");
         read_reg(sys_pkg::SYS_REG_UART_DATA, rd);
         check_value("uart_data", "loopback byte", rd, tx);
         read_reg(sys_pkg::SYS_REG_UART_STAT, rd);
         check_value("uart_stat avail", $sformatf("popped %h", tx), rd[0], 1'b0);
         poll_status(1, 1'b0, "transmit idle");
      end

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, hung);
      if (errors == 0 && !hung) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
src/sys_pkg.sv
src/edge_detector.sv
src/interval_timer.sv
src/uart_link.sv
src/sys_ctl_regs.sv
src/spram.sv
src/bus_controller.sv
src/sys_bus_top.sv
tb/tb_sys_bus.sv
